// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_invaders_display
FILELIST ?= list.f
OBJ_DIR ?= obj_dir
BUILD_FLAGS ?= --binary --timing
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_MSG ?= *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# pass only if the simulation printed the pass message
run: build
	@out="$$($(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== design/alien_cell.sv ====
`timescale 1ns/1ps
`default_nettype none

module alien_cell #(
	parameter int col = 0,
	parameter int row = 0
) (
	input logic clk,
	input logic rst,
	input logic laser_valid,
	input invaders_pkg::fleet_cmd_t cmd,
	input invaders_pkg::screen_mode_t mode,
	input invaders_pkg::coord_t laser_x,
	input invaders_pkg::coord_t laser_y,
	input invaders_pkg::coord_t x,
	input invaders_pkg::coord_t y,
	output logic at_edge,
	output logic on_alien
);
	import invaders_pkg::*;

	// top-left corner of the box
	coord_t pos_x;
	coord_t pos_y;
	logic alive;
	// tracks the controller direction
	logic dir_right;
	logic laser_in_box;
	logic pixel_in_box;

	////////////////////////////////////////
	// position and direction

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			// home slot from grid position
			pos_x <= coord_t'(fleet_x0 + col * col_pitch);
			pos_y <= coord_t'(fleet_y0 + row * row_pitch);
			dir_right <= 1'b1;
		end else begin
			case (cmd)
				cmd_right: begin
					pos_x <= pos_x + step_x;
					dir_right <= 1'b1;
				end
				cmd_left: begin
					pos_x <= pos_x - step_x;
					dir_right <= 1'b0;
				end
				cmd_down: begin
					// drop, the controller reverses here too
					pos_y <= pos_y + step_y;
					dir_right <= ~dir_right;
				end
				default: ;
			endcase
		end
	end

	////////////////////////////////////////
	// laser hit

	assign laser_in_box = laser_x >= pos_x && laser_x < pos_x + alien_w &&
		laser_y >= pos_y && laser_y < pos_y + alien_h;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			alive <= 1'b1;
		end else if (alive && mode == mode_game && laser_valid && laser_in_box) begin
			alive <= 1'b0;
		end
	end

	// pixel and edge flags
	assign pixel_in_box = x >= pos_x && x < pos_x + alien_w &&
		y >= pos_y && y < pos_y + alien_h;
	assign on_alien = alive & pixel_in_box;

	// next step would leave the screen
	assign at_edge = alive &&
		(dir_right ? (pos_x + alien_w + step_x > screen_w) : (pos_x < step_x));

endmodule

`default_nettype wire

// ==== design/fleet_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface fleet_if;
	import invaders_pkg::*;

	// from the march controller
	fleet_cmd_t cmd;
	screen_mode_t mode;
	// one bit per alien cell
	logic [fleet_n-1:0] at_edge;
	logic [fleet_n-1:0] on_alien;

	modport motion (
		output cmd,
		output mode,
		input at_edge
	);

	modport pixel (
		input mode,
		input on_alien
	);

endinterface

`default_nettype wire

// ==== design/fleet_motion.sv ====
`timescale 1ns/1ps
`default_nettype none

module fleet_motion (
	input logic clk,
	input logic rst,
	input logic button_display,
	input logic alien_step,
	fleet_if.motion fleet
);
	import invaders_pkg::*;

	logic button_sync;
	logic button_prev;
	logic press;
	// 1 while marching right
	logic dir_right;

	////////////////////////////////////////
	// screen mode sequencer

	// sample then compare with last sample
	assign press = button_sync & ~button_prev;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			button_sync <= 1'b0;
			button_prev <= 1'b0;
			fleet.mode <= mode_black;
		end else begin
			button_sync <= button_display;
			button_prev <= button_sync;
			if (press) begin
				// black -> start -> game -> black
				case (fleet.mode)
					mode_black: fleet.mode <= mode_start;
					mode_start: fleet.mode <= mode_game;
					default: fleet.mode <= mode_black;
				endcase
			end
		end
	end

	////////////////////////////////////////
	// march controller

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			fleet.cmd <= cmd_hold;
			dir_right <= 1'b1;
		end else if (alien_step && fleet.mode == mode_game) begin
			if (|fleet.at_edge) begin
				// edge reached, drop and turn around
				fleet.cmd <= cmd_down;
				dir_right <= ~dir_right;
			end else begin
				fleet.cmd <= dir_right ? cmd_right : cmd_left;
			end
		end else begin
			// single-cycle command
			fleet.cmd <= cmd_hold;
		end
	end

endmodule

`default_nettype wire

// ==== design/frame_compositor.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_compositor (
	input logic clk,
	input logic rst,
	input invaders_pkg::coord_t x,
	input invaders_pkg::coord_t y,
	fleet_if.pixel fleet,
	output invaders_pkg::rgb_t rgb
);
	import invaders_pkg::*;

	logic visible;
	logic on_scoreboard;
	logic on_barrier;
	logic on_lives;
	// space when no alien covers the pixel
	rgb_t alien_color;

	assign visible = x < screen_w && y < screen_h;

	// border lines
	assign on_scoreboard = y == scoreboard_top || y == scoreboard_bottom;
	assign on_barrier = y == barrier_top || y == barrier_bottom;
	assign on_lives = y == lives_top || y == lives_bottom;

	////////////////////////////////////////
	// alien priority

	// walk down from the top index so the lowest hit wins
	always_comb begin
		alien_color = color_space;
		for (int i = fleet_n - 1; i >= 0; i--) begin
			if (fleet.on_alien[i]) begin
				// first row cells take row0 colour
				alien_color = (i < fleet_cols) ? color_alien_row0 : color_alien_row1;
			end
		end
	end

	////////////////////////////////////////
	// output register

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rgb <= color_black;
		end else if (!visible) begin
			rgb <= color_black;
		end else begin
			case (fleet.mode)
				mode_start: begin
					rgb <= color_start;
				end
				mode_game: begin
					// borders first, then aliens
					if (on_scoreboard) begin
						rgb <= color_red;
					end else if (on_barrier) begin
						rgb <= color_blue;
					end else if (on_lives) begin
						rgb <= color_green;
					end else begin
						rgb <= alien_color;
					end
				end
				default: begin
					// blank screen
					rgb <= color_black;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== design/invaders_display.sv ====
`timescale 1ns/1ps
`default_nettype none

module invaders_display (
	input logic clk,
	input logic rst,
	input logic button_display,
	input logic alien_step,
	input logic laser_valid,
	input invaders_pkg::coord_t laser_x,
	input invaders_pkg::coord_t laser_y,
	input invaders_pkg::coord_t x,
	input invaders_pkg::coord_t y,
	output invaders_pkg::rgb_t rgb
);
	import invaders_pkg::*;

	fleet_if fleet ();

	// mode and march commands
	fleet_motion u_fleet_motion (
		.clk (clk),
		.rst (rst),
		.button_display (button_display),
		.alien_step (alien_step),
		.fleet (fleet.motion)
	);

	////////////////////////////////////////
	// alien grid, index = row * cols + col
	for (genvar i = 0; i < fleet_n; i++) begin : g_alien
		alien_cell #(
			.col (i % fleet_cols),
			.row (i / fleet_cols)
		) u_alien_cell (
			.clk (clk),
			.rst (rst),
			.laser_valid (laser_valid),
			.cmd (fleet.cmd),
			.mode (fleet.mode),
			.laser_x (laser_x),
			.laser_y (laser_y),
			.x (x),
			.y (y),
			.at_edge (fleet.at_edge[i]),
			.on_alien (fleet.on_alien[i])
		);
	end

	// pixel colour, one cycle behind x and y
	frame_compositor u_frame_compositor (
		.clk (clk),
		.rst (rst),
		.x (x),
		.y (y),
		.fleet (fleet.pixel),
		.rgb (rgb)
	);

endmodule

`default_nettype wire

// ==== design/invaders_pkg.sv ====
`default_nettype none

package invaders_pkg;

	////////////////////////////////////////
	// screen geometry
	localparam int coord_w = 11;
	typedef logic [coord_w-1:0] coord_t;

	localparam coord_t screen_w = 11'd640;
	localparam coord_t screen_h = 11'd480;

	// horizontal border rows
	localparam coord_t scoreboard_top = 11'd0;
	localparam coord_t scoreboard_bottom = 11'd40;
	localparam coord_t barrier_top = 11'd340;
	localparam coord_t barrier_bottom = 11'd400;
	localparam coord_t lives_top = 11'd460;
	// last visible line
	localparam coord_t lives_bottom = 11'd479;

	////////////////////////////////////////
	// fleet layout
	localparam int fleet_cols = 11;
	localparam int fleet_rows = 2;
	localparam int fleet_n = fleet_cols * fleet_rows;

	// top-left alien
	localparam coord_t fleet_x0 = 11'd70;
	localparam coord_t fleet_y0 = 11'd90;
	localparam coord_t col_pitch = 11'd50;
	localparam coord_t row_pitch = 11'd30;
	localparam coord_t alien_w = 11'd30;
	localparam coord_t alien_h = 11'd20;
	// march distances
	localparam coord_t step_x = 11'd10;
	localparam coord_t step_y = 11'd10;

	////////////////////////////////////////
	// colours, blue 2 | green 3 | red 3
	typedef logic [7:0] rgb_t;

	localparam rgb_t color_black = 8'b00_000_000;
	localparam rgb_t color_start = 8'b00_111_111;
	localparam rgb_t color_red = 8'b00_000_111;
	localparam rgb_t color_blue = 8'b11_000_000;
	localparam rgb_t color_green = 8'b00_111_000;
	localparam rgb_t color_alien_row0 = 8'b10_101_010;
	localparam rgb_t color_alien_row1 = 8'b01_111_000;
	// dark blue background, kept apart from black
	localparam rgb_t color_space = 8'b01_000_000;

	typedef enum logic [1:0] {mode_black, mode_start, mode_game} screen_mode_t;
	typedef enum logic [1:0] {cmd_hold, cmd_left, cmd_right, cmd_down} fleet_cmd_t;

endpackage

`default_nettype wire

// ==== list.f ====
+incdir+testbench
design/invaders_pkg.sv
design/fleet_if.sv
design/fleet_motion.sv
design/alien_cell.sv
design/frame_compositor.sv
design/invaders_display.sv
testbench/tb_invaders_display.sv

// ==== testbench/tb_invaders_model.svh ====
`ifndef TB_INVADERS_MODEL_SVH
`define TB_INVADERS_MODEL_SVH
`default_nettype none

import invaders_pkg::*;

////////////////////////////////////////
// reference fleet, top-left corner per alien
int ref_x [fleet_n];
int ref_y [fleet_n];
bit ref_alive [fleet_n];
bit ref_dir_right;
screen_mode_t ref_mode;

function automatic void reset_fleet();
	ref_mode = mode_black;
	ref_dir_right = 1'b1;
	for (int i = 0; i < fleet_n; i++) begin
		ref_x[i] = int'(fleet_x0) + (i % fleet_cols) * int'(col_pitch);
		ref_y[i] = int'(fleet_y0) + (i / fleet_cols) * int'(row_pitch);
		ref_alive[i] = 1'b1;
	end
endfunction

// black, start, game, black
function automatic void advance_mode();
	case (ref_mode)
		mode_black: ref_mode = mode_start;
		mode_start: ref_mode = mode_game;
		default: ref_mode = mode_black;
	endcase
endfunction

function automatic bit inside_box(int i, int px, int py);
	return px >= ref_x[i] && px < ref_x[i] + int'(alien_w) &&
		py >= ref_y[i] && py < ref_y[i] + int'(alien_h);
endfunction

// any live alien whose next sideways step leaves the screen
function automatic bit edge_reached();
	for (int i = 0; i < fleet_n; i++) begin
		if (ref_alive[i] && (ref_dir_right ?
			ref_x[i] + int'(alien_w) + int'(step_x) > int'(screen_w) :
			ref_x[i] < int'(step_x))) begin
			return 1'b1;
		end
	end
	return 1'b0;
endfunction

function automatic void march_fleet();
	bit drop;
	if (ref_mode != mode_game) begin
		return;
	end
	drop = edge_reached();
	for (int i = 0; i < fleet_n; i++) begin
		// dead aliens keep marching with the rest
		ref_x[i] += drop ? 0 : (ref_dir_right ? int'(step_x) : -int'(step_x));
		ref_y[i] += drop ? int'(step_y) : 0;
	end
	if (drop) begin
		ref_dir_right = !ref_dir_right;
	end
endfunction

function automatic void fire_laser(int lx, int ly);
	for (int i = 0; i < fleet_n; i++) begin
		if (ref_mode == mode_game && ref_alive[i] && inside_box(i, lx, ly)) begin
			ref_alive[i] = 1'b0;
		end
	end
endfunction

// colour of one pixel, borders above aliens, lowest index wins
function automatic rgb_t expected_color(int px, int py);
	if (px >= int'(screen_w) || py >= int'(screen_h) || ref_mode == mode_black) begin
		return color_black;
	end
	if (ref_mode == mode_start) begin
		return color_start;
	end
	if (py == int'(scoreboard_top) || py == int'(scoreboard_bottom)) begin
		return color_red;
	end
	if (py == int'(barrier_top) || py == int'(barrier_bottom)) begin
		return color_blue;
	end
	if (py == int'(lives_top) || py == int'(lives_bottom)) begin
		return color_green;
	end
	for (int i = 0; i < fleet_n; i++) begin
		if (ref_alive[i] && inside_box(i, px, py)) begin
			return (i < fleet_cols) ? color_alien_row0 : color_alien_row1;
		end
	end
	return color_space;
endfunction

`default_nettype wire
`endif

// ==== testbench/tb_invaders_display.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_invaders_display;
	`include "tb_invaders_model.svh"

	typedef enum logic [1:0] {act_press, act_step, act_laser, act_probe} action_t;

	// px and py hold the probe or laser point
	typedef struct packed {
		action_t action;
		coord_t px;
		coord_t py;
		rgb_t expected;
		logic from_model;
	} entry_t;

	logic clk;
	logic rst;
	logic button_display;
	logic alien_step;
	logic laser_valid;
	coord_t laser_x;
	coord_t laser_y;
	coord_t x;
	coord_t y;
	rgb_t rgb;

	entry_t table_q[$];
	int pass_count;
	int fail_count;

	invaders_display u_invaders_display (
		.clk (clk),
		.rst (rst),
		.button_display (button_display),
		.alien_step (alien_step),
		.laser_valid (laser_valid),
		.laser_x (laser_x),
		.laser_y (laser_y),
		.x (x),
		.y (y),
		.rgb (rgb)
	);

	// 100 ns period
	always #50 clk = ~clk;

	////////////////////////////////////////
	// helpers

	// returns 5 ns after the nth rising edge
	task automatic wait_cycles(int n);
		time limit;
		int seen;
		limit = $time + 64'(100 * n + 50);
		seen = 0;
		while (seen < n) begin
			@(posedge clk);
			seen++;
			if ($time > limit) begin
				$display("timeout: clock stalled while waiting %0d cycles", n);
				$display("*** TEST FAILED ***");
				$finish;
			end
		end
		#5;
	endtask

	function automatic void add_entry(action_t action, int px, int py, rgb_t expected,
		logic from_model);
		entry_t e;
		e.action = action;
		e.px = coord_t'(px);
		e.py = coord_t'(py);
		e.expected = expected;
		e.from_model = from_model;
		table_q.push_back(e);
	endfunction

	task automatic apply_entry(int idx, entry_t e);
		rgb_t want;
		case (e.action)
			act_press: begin
				button_display = 1'b1;
				wait_cycles(1);
				button_display = 1'b0;
				advance_mode();
				wait_cycles(3);
				$display("test %0d: press, mode now %s", idx, ref_mode.name());
			end
			act_step: begin
				alien_step = 1'b1;
				wait_cycles(1);
				alien_step = 1'b0;
				march_fleet();
				wait_cycles(3);
				$display("test %0d: step", idx);
			end
			act_laser: begin
				laser_x = e.px;
				laser_y = e.py;
				laser_valid = 1'b1;
				wait_cycles(1);
				laser_valid = 1'b0;
				fire_laser(int'(e.px), int'(e.py));
				wait_cycles(3);
				$display("test %0d: laser at (%0d,%0d)", idx, e.px, e.py);
			end
			default: begin
				x = e.px;
				y = e.py;
				// rgb lags one register stage
				wait_cycles(2);
				want = e.from_model ? expected_color(int'(e.px), int'(e.py)) : e.expected;
				if (rgb !== want) begin
					$display("FAILED at %0t: test %0d probe (%0d,%0d) gave %h, expected %h",
						$time, idx, e.px, e.py, rgb, want);
					fail_count++;
				end else begin
					$display("test %0d: probe (%0d,%0d) = %h ok", idx, e.px, e.py, rgb);
					pass_count++;
				end
			end
		endcase
	endtask

	////////////////////////////////////////
	// stimulus table and run

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		button_display = 1'b0;
		alien_step = 1'b0;
		laser_valid = 1'b0;
		laser_x = '0;
		laser_y = '0;
		x = '0;
		y = '0;
		pass_count = 0;
		fail_count = 0;
		reset_fleet();

		// black after reset then a start screen that ignores steps
		add_entry(act_probe, 300, 200, color_black, 1'b0);
		add_entry(act_press, 0, 0, 8'h00, 1'b0);
		add_entry(act_probe, 300, 200, color_start, 1'b0);
		add_entry(act_step, 0, 0, 8'h00, 1'b0);
		// game mode with borders and fleet at home
		add_entry(act_press, 0, 0, 8'h00, 1'b0);
		add_entry(act_probe, 300, 0, color_red, 1'b0);
		add_entry(act_probe, 300, 340, color_blue, 1'b0);
		add_entry(act_probe, 300, 460, color_green, 1'b0);
		// past the right edge on a border row
		add_entry(act_probe, 700, 0, color_black, 1'b0);
		add_entry(act_probe, 75, 95, color_alien_row0, 1'b0);
		add_entry(act_probe, 75, 125, color_alien_row1, 1'b0);
		add_entry(act_probe, 300, 200, color_space, 1'b0);
		// one step right
		add_entry(act_step, 0, 0, 8'h00, 1'b0);
		add_entry(act_probe, 70, 95, color_space, 1'b0);
		add_entry(act_probe, 80, 95, color_alien_row0, 1'b0);
		// march until col 10 starts at x 610
		add_entry(act_step, 0, 0, 8'h00, 1'b0);
		add_entry(act_step, 0, 0, 8'h00, 1'b0);
		add_entry(act_step, 0, 0, 8'h00, 1'b0);
		add_entry(act_probe, 615, 95, color_alien_row0, 1'b0);
		// drop without sideways move
		add_entry(act_step, 0, 0, 8'h00, 1'b0);
		add_entry(act_probe, 110, 95, color_space, 1'b0);
		add_entry(act_probe, 110, 115, color_alien_row0, 1'b0);
		add_entry(act_probe, 105, 115, color_space, 1'b0);
		// then left
		add_entry(act_step, 0, 0, 8'h00, 1'b0);
		add_entry(act_probe, 100, 115, 8'h00, 1'b1);
		add_entry(act_probe, 130, 115, color_space, 1'b0);
		// kill alien 0 then miss
		add_entry(act_laser, 110, 110, 8'h00, 1'b0);
		add_entry(act_probe, 110, 110, color_space, 1'b0);
		add_entry(act_laser, 300, 200, 8'h00, 1'b0);
		add_entry(act_probe, 155, 105, 8'h00, 1'b1);
		// mode wraps while the fleet stays put
		add_entry(act_press, 0, 0, 8'h00, 1'b0);
		add_entry(act_probe, 155, 105, color_black, 1'b0);
		add_entry(act_press, 0, 0, 8'h00, 1'b0);
		add_entry(act_probe, 155, 105, color_start, 1'b0);
		add_entry(act_press, 0, 0, 8'h00, 1'b0);
		add_entry(act_probe, 155, 105, 8'h00, 1'b1);
		add_entry(act_probe, 110, 110, 8'h00, 1'b1);

		wait_cycles(10);
		rst = 1'b0;
		wait_cycles(2);
		foreach (table_q[i]) begin
			apply_entry(i, table_q[i]);
		end

		$display("done: %0d checks passed, %0d failed", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire
